// ==== baud_tick_gen.sv ====
// ========================================
// Baud tick generator
// One-cycle tick at 16x the bit rate
// ========================================

`timescale 1ns/1ps

module baud_tick_gen import uart_pkg::*; #(
    parameter int unsigned CLK_FREQ  = 1_600_000,   // Hz
    parameter int unsigned BAUD_RATE = 10_000       // Bits per second
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    // Clock cycles per tick
    localparam int unsigned DIVISOR = CLK_FREQ / (OVERSAMPLE * BAUD_RATE);
    localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVISOR - 1);

    logic [CNT_W-1:0] div_cnt;                  // Free-running divider

    // ========================================
    // Elaboration check
    // ========================================

    if (DIVISOR < 2) begin : g_div_check
        $error("baud_tick_gen: CLK_FREQ too low for BAUD_RATE x OVERSAMPLE");
    end

    // ========================================
    // Divider
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= (div_cnt == CNT_LAST);      // One pulse per wrap
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;                  // Wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_uart -o tb_uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build error"
    exit 1
fi

./obj_dir/tb_uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== tb.f ====
uart_pkg.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
uart_top.sv
tb_clk_gen.sv
tb_uart.sv

// ==== tb_clk_gen.sv ====
// ========================================
// Testbench clock and reset source
// ========================================

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_NS    = 50,              // Half period, 100 ns clock
    parameter int RST_CYCLES = 10               // Cycles with arst_n low
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;          // Free-running
    end

    initial begin
        arst_n = 1'b0;                          // Asserted from time zero
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                          // Release away from the active edge
    end

endmodule

// ==== tb_uart.sv ====
// ========================================
// UART testbench
// Random bytes through TX, RX and loopback
// ========================================

`timescale 1ns/1ps

module tb_uart;

    localparam int BIT_CYC   = 160;             // clk cycles per bit
    localparam int FRAME_CYC = 10 * BIT_CYC;    // 8N1 frame
    localparam int N_TX      = 20;
    localparam int N_LOOP    = 30;
    localparam int N_ERR     = 6;
    localparam int N_GLITCH  = 3;
    localparam int N_IGN     = 4;

    logic        clk;
    logic        arst_n;
    logic        rx;
    logic        tx_start;
    logic [7:0]  tx_data;
    logic        tx;
    logic        tx_busy;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_frame_err;
    logic        use_loop;                      // Line mux select
    logic        enc_line;                      // Frame encoder output
    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  b;
    logic [7:0]  b2;
    int          cnt;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          valid_cnt = 0;                 // rx_valid pulses seen

    tb_clk_gen #(.HALF_NS(50), .RST_CYCLES(10)) clk_i (.clk(clk), .arst_n(arst_n));

    uart_top dut_i (
        .clk(clk), .arst_n(arst_n), .rx(rx), .tx_start(tx_start), .tx_data(tx_data),
        .tx(tx), .tx_busy(tx_busy), .rx_data(rx_data), .rx_valid(rx_valid),
        .rx_frame_err(rx_frame_err)
    );

    assign rx = use_loop ? tx : enc_line;       // Loopback or encoder

    always @(posedge clk) begin
        if (arst_n && rx_valid) begin
            valid_cnt <= valid_cnt + 1;         // Pulse monitor
        end
    end

    // ========================================
    // Checks and waits
    // ========================================

    task automatic compare_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("FAIL %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("FAIL %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        chk_cnt++;
        assert (act == exp) else begin
            err_cnt++;
            $display("FAIL %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic wait_tx_free(input int limit);
        int n;
        n = 0;
        while (tx_busy !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (tx_busy === 1'b0) else begin
            err_cnt++;
            $display("ERROR timed out waiting for tx_busy to fall at %0t", $time);
        end
    endtask

    task automatic wait_tx_low(input int limit);
        int n;
        n = 0;
        while (tx !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (tx === 1'b0) else begin
            err_cnt++;
            $display("ERROR timed out waiting for the start bit on tx at %0t", $time);
        end
    endtask

    task automatic wait_frame(input int base, input int limit);
        int n;
        n = 0;
        while (valid_cnt == base && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (valid_cnt != base) else begin
            err_cnt++;
            $display("ERROR no rx_valid pulse within %0d cycles at %0t", limit, $time);
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    task automatic next_byte(output logic [7:0] val);
        rnd = $random(seed);
        val = rnd[7:0];
    endtask

    // One-cycle strobe once the transmitter is free
    task automatic load_byte(input logic [7:0] val);
        wait_tx_free(2 * FRAME_CYC);
        tx_start = 1'b1;
        tx_data  = val;
        @(negedge clk);
        tx_start = 1'b0;
    endtask

    // 8N1 line encoder, LSB first, with a selectable stop level
    task automatic drive_frame(input logic [7:0] val, input logic stop_lvl);
        enc_line = 1'b0;                        // Start bit
        repeat (BIT_CYC) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            enc_line = val[i];
            repeat (BIT_CYC) @(negedge clk);
        end
        enc_line = stop_lvl;
        repeat (BIT_CYC) @(negedge clk);
        enc_line = 1'b1;                        // Idle gap of two bits
        repeat (2 * BIT_CYC) @(negedge clk);
    endtask

    // Mid-bit samples timed from the start edge
    task automatic check_tx_frame(input logic [7:0] val);
        compare_bit("tx_busy", 1'b1, tx_busy);
        wait_tx_low(2 * BIT_CYC);
        repeat (BIT_CYC / 2) @(negedge clk);
        compare_bit("tx start bit", 1'b0, tx);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            compare_bit($sformatf("tx data bit %0d", i), val[i], tx);
        end
        repeat (BIT_CYC) @(negedge clk);
        compare_bit("tx stop bit", 1'b1, tx);
        compare_bit("tx_busy", 1'b1, tx_busy);  // Still busy in the stop bit
        wait_tx_free(BIT_CYC + BIT_CYC / 2);    // Falls at end of stop bit
    endtask

    task automatic check_rx(input logic [7:0] val, input logic ferr);
        compare_byte("rx_data", val, rx_data);
        compare_bit("rx_frame_err", ferr, rx_frame_err);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        seed     = 32'ha32d_5874;
        tx_start = 1'b0;
        tx_data  = 8'h00;
        use_loop = 1'b0;
        enc_line = 1'b1;                        // Idle line

        repeat (3) @(negedge clk);              // Inside reset
        compare_bit("tx", 1'b1, tx);
        compare_bit("tx_busy", 1'b0, tx_busy);
        compare_bit("rx_valid", 1'b0, rx_valid);
        cnt = 0;
        while (arst_n !== 1'b1 && cnt < 40) begin
            @(negedge clk);
            cnt++;
        end
        assert (arst_n === 1'b1) else begin
            err_cnt++;
            $display("ERROR reset was never released");
        end
        @(negedge clk);
        compare_bit("tx", 1'b1, tx);
        compare_bit("tx_busy", 1'b0, tx_busy);
        compare_bit("rx_valid", 1'b0, rx_valid);
        compare_bit("rx_frame_err", 1'b0, rx_frame_err);
        compare_byte("rx_data", 8'h00, rx_data);

        for (int k = 0; k < N_TX; k++) begin    // Transmit framing
            next_byte(b);
            load_byte(b);
            check_tx_frame(b);
        end

        use_loop = 1'b1;                        // Loopback
        cnt = valid_cnt;
        for (int k = 0; k < N_LOOP; k++) begin
            next_byte(b);
            load_byte(b);
            wait_frame(cnt + k, 2 * FRAME_CYC);
            check_rx(b, 1'b0);
        end
        wait_tx_free(2 * FRAME_CYC);
        repeat (BIT_CYC) @(negedge clk);
        compare_count("rx_valid pulses", cnt + N_LOOP, valid_cnt);

        use_loop = 1'b0;                        // Encoder drives rx
        for (int k = 0; k < N_ERR; k++) begin
            next_byte(b);
            cnt = valid_cnt;
            drive_frame(b, 1'b0);               // Low stop bit
            wait_frame(cnt, FRAME_CYC);
            check_rx(b, 1'b1);
            next_byte(b);
            cnt = valid_cnt;
            drive_frame(b, 1'b1);               // Good frame clears the flag
            wait_frame(cnt, FRAME_CYC);
            check_rx(b, 1'b0);
        end

        for (int k = 0; k < N_GLITCH; k++) begin
            rnd = $random(seed);
            cnt = valid_cnt;
            enc_line = 1'b0;                    // 5 to 36 cycles, under a quarter bit
            repeat (5 + int'(rnd[4:0])) @(negedge clk);
            enc_line = 1'b1;
            repeat (2 * FRAME_CYC) @(negedge clk);
            compare_count("rx_valid pulses after glitch", cnt, valid_cnt);
            next_byte(b);
            drive_frame(b, 1'b1);
            wait_frame(cnt, FRAME_CYC);
            check_rx(b, 1'b0);
        end

        use_loop = 1'b1;                        // Start strobe while busy
        for (int k = 0; k < N_IGN; k++) begin
            next_byte(b);
            next_byte(b2);
            if (b2 == b) begin
                b2 = ~b;
            end
            cnt = valid_cnt;
            load_byte(b);
            rnd = $random(seed);
            repeat (1 + int'(rnd[9:0])) @(negedge clk);
            compare_bit("tx_busy", 1'b1, tx_busy);
            tx_start = 1'b1;
            tx_data  = b2;
            @(negedge clk);
            tx_start = 1'b0;
            wait_frame(cnt, 2 * FRAME_CYC);
            check_rx(b, 1'b0);
            wait_tx_free(BIT_CYC);
            repeat (BIT_CYC) @(negedge clk);
            compare_bit("tx_busy", 1'b0, tx_busy);
            compare_count("rx_valid pulses", cnt + 1, valid_cnt);
        end

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== uart_pkg.sv ====
// ========================================
// UART shared definitions
// Frame constants and FSM phase encoding
// ========================================

package uart_pkg;

    // ========================================
    // Frame geometry
    // ========================================

    // Ticks per bit period
    localparam int OVERSAMPLE = 16;

    // Middle of a bit, counted in ticks
    localparam int MID_BIT = OVERSAMPLE / 2;

    // 8N1 payload, LSB first on the line
    localparam int DATA_BITS = 8;

    // Width of a data bit index
    localparam int BIT_W = $clog2(DATA_BITS);

    // ========================================
    // Frame phases
    // ========================================

    // Shared by the receive and transmit FSMs
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                           // Line high, waiting
        START = 2'd1,                           // Start bit, line low
        DATA  = 2'd2,                           // Eight data bits
        STOP  = 2'd3                            // Stop bit, line high
    } uart_state_t;

endpackage

// ==== uart_rx.sv ====
// ========================================
// UART receiver, 8N1
// Mid-bit sampling with glitch filter
// and stop-bit check
// ========================================

`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tick,
    input  logic                 rx,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 rx_frame_err
);

    // Counter must reach half a bit past the middle of the stop bit
    localparam int CNT_W = $clog2(OVERSAMPLE + MID_BIT);
    localparam logic [CNT_W-1:0] MID_TICK  = CNT_W'(MID_BIT - 1);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(OVERSAMPLE - 1);
    localparam logic [CNT_W-1:0] DONE_TICK = CNT_W'(OVERSAMPLE + MID_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(DATA_BITS - 1);

    uart_state_t          state;                // Frame phase
    logic                 rx_meta;              // Sync stage 1
    logic                 rx_sync;              // Sync stage 2, safe to use
    logic [CNT_W-1:0]     tick_cnt;             // Ticks within current bit
    logic [BIT_W-1:0]     bit_idx;              // Data bit being received
    logic [DATA_BITS-1:0] shreg;                // Incoming byte, LSB first
    logic                 stop_smp;             // Line level at mid stop bit
    logic                 sample_pt;            // Tick at the middle of a bit

    assign sample_pt = tick && (tick_cnt == LAST_TICK);

    // ========================================
    // Line synchronizer
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;                    // Idle line is high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ========================================
    // Data path
    // ========================================

    always_ff @(posedge clk) begin
        if (state == DATA && sample_pt) begin
            shreg <= {rx_sync, shreg[DATA_BITS-1:1]};   // Shift in from the top
        end
        if (state == STOP && sample_pt) begin
            stop_smp <= rx_sync;                // Middle of stop bit
        end
    end

    // ========================================
    // Receive FSM
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            tick_cnt     <= '0;
            bit_idx      <= '0;
            rx_data      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid <= 1'b0;                   // Pulse only
            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    if (!rx_sync) begin
                        state <= START;         // Falling edge seen
                    end
                end
                START: begin
                    if (tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            // Still low at mid start bit, else a glitch
                            state <= rx_sync ? IDLE : DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            if (bit_idx == LAST_BIT) begin
                                state <= STOP;  // Byte complete
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (tick) begin
                        if (tick_cnt == DONE_TICK) begin
                            // Half a bit after the stop sample
                            state        <= IDLE;
                            tick_cnt     <= '0;
                            rx_data      <= shreg;
                            rx_frame_err <= !stop_smp;  // Low stop bit
                            rx_valid     <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ========================================
    // Assertions
    // ========================================

    // One frame, one single-cycle strobe
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) rx_valid |=> !rx_valid
    ) else $error("uart_rx: rx_valid high for two cycles");

endmodule

// ==== uart_top.sv ====
// ========================================
// UART top level
// Tick generator, receiver, transmitter
// ========================================

`timescale 1ns/1ps

module uart_top #(
    parameter int unsigned CLK_FREQ  = 1_600_000,   // Hz
    parameter int unsigned BAUD_RATE = 10_000       // Bits per second
) (
    input  logic       clk,
    input  logic       arst_n,
    // Serial line in
    input  logic       rx,
    // Transmit side
    input  logic       tx_start,                // Strobe, taken when not busy
    input  logic [7:0] tx_data,
    output logic       tx,                      // Serial line out
    output logic       tx_busy,
    // Receive side
    output logic [7:0] rx_data,                 // Held until next frame
    output logic       rx_valid,                // One cycle per frame
    output logic       rx_frame_err             // Stop bit was low
);

    logic tick;                                 // 16x oversampling strobe

    // Shared rate source
    baud_tick_gen #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_tick (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick)
    );

    uart_rx u_rx (
        .clk          (clk),
        .arst_n       (arst_n),
        .tick         (tick),
        .rx           (rx),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== uart_tx.sv ====
// ========================================
// UART transmitter, 8N1
// Latches a byte and shifts out a frame
// ========================================

`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tick,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx,
    output logic                 tx_busy
);

    localparam int CNT_W = $clog2(OVERSAMPLE);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(DATA_BITS - 1);

    uart_state_t          state;                // Frame phase
    logic [CNT_W-1:0]     tick_cnt;             // Bit-phase counter
    logic [BIT_W-1:0]     bit_idx;              // Data bit on the line
    logic [DATA_BITS-1:0] shreg;                // Outgoing byte, LSB at [0]
    logic                 accept;               // Byte taken this cycle
    logic                 bit_end;              // Last tick of a bit period

    assign accept  = tx_start && !tx_busy;      // Ignored while busy
    assign bit_end = tick && (tick_cnt == LAST_TICK);

    // ========================================
    // Data path
    // ========================================

    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= tx_data;                   // Latch on acceptance
        end else if (state == DATA && bit_end) begin
            shreg <= shreg >> 1;                // Next bit to [0]
        end
    end

    // ========================================
    // Transmit FSM
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;                   // Line idles high
            tx_busy  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= START;
                        tx_busy  <= 1'b1;
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                    end
                end
                START: begin
                    if (tick) begin
                        if (tx) begin
                            tx <= 1'b0;         // Start edge on first tick
                        end else if (tick_cnt == LAST_TICK) begin
                            state    <= DATA;
                            tick_cnt <= '0;
                            tx       <= shreg[0];   // Bit 0 first
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_idx == LAST_BIT) begin
                            state <= STOP;
                            tx    <= 1'b1;      // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[1];    // Before the shift lands
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state    <= IDLE;
                        tick_cnt <= '0;
                        tx_busy  <= 1'b0;       // Frame done, 160 ticks
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ========================================
    // Assertions
    // ========================================

    a_idle_line: assert property (
        @(posedge clk) disable iff (!arst_n) (state == IDLE) |-> tx
    ) else $error("uart_tx: tx low while idle");

    a_busy_frame: assert property (
        @(posedge clk) disable iff (!arst_n) (state != IDLE) |-> tx_busy
    ) else $error("uart_tx: tx_busy low during a frame");

endmodule
